// ==== hdl/femto8_pkg.sv ====
package femto8_pkg;

	// instruction pointer after reset or a reset instruction
	localparam logic [7:0] RESET_VECTOR = 8'h80;

	// stores always land in the low page
	localparam logic [3:0] STORE_PAGE = 4'h0;

	// fixed single-byte instructions
	localparam logic [7:0] SWAP_OPCODE = 8'b1000_0001;
	localparam logic [7:0] CLC_OPCODE  = 8'b1000_1000;

	// alu operations, low nibble of a compute opcode
	typedef enum logic [3:0] {
		op_zero   = 4'h0,
		op_load_a = 4'h1,
		op_inc    = 4'h2,
		op_dec    = 4'h3,
		op_asl    = 4'h4,
		op_lsr    = 4'h5,
		op_rol    = 4'h6,
		op_ror    = 4'h7,
		op_or     = 4'h8,
		op_and    = 4'h9,
		op_xor    = 4'ha,
		op_load_b = 4'hb,
		op_add    = 4'hc,
		op_sub    = 4'hd,
		op_adc    = 4'he,
		op_sbb    = 4'hf
	} alu_op_e;

	// compute destination, bits 5:4 of the opcode
	typedef enum logic [1:0] {
		dest_a    = 2'b00,
		dest_b    = 2'b01,
		dest_ip   = 2'b10,
		dest_none = 2'b11
	} dest_e;

	typedef enum logic [2:0] {
		st_reset   = 3'd0,
		st_select  = 3'd1,
		st_decode  = 3'd2,
		st_operand = 3'd3,
		st_compute = 3'd4,
		st_read_ip = 3'd5
	} seq_state_e;

	// one compute step, valid only in the compute state
	typedef struct packed {
		alu_op_e alu_op;
		dest_e   dest;
		logic    from_bus;
		logic    flag_en;
		logic    swap;
		logic    clr_carry;
		logic    valid;
	} exec_cmd_t;

	// carry-out sits above the value, same layout as a 9-bit sum
	typedef struct packed {
		logic       carry;
		logic [7:0] value;
	} alu_result_t;

	typedef struct packed {
		logic       valid;
		logic       write;
		logic [7:0] adr;
		logic [7:0] wdata;
	} bus_req_t;

endpackage

// ==== hdl/wb_master.sv ====
module wb_master (
	input  logic                clk,
	input  logic                reset,
	input  femto8_pkg::bus_req_t req,
	output logic                done,
	output logic [7:0]          rdata,
	output logic                cyc,
	output logic                stb,
	output logic                we,
	output logic [7:0]          adr,
	output logic [7:0]          dat_o,
	input  logic [7:0]          dat_i,
	input  logic                ack
);
	import femto8_pkg::*;

	typedef enum logic {
		wb_idle,
		wb_active
	} wb_state_e;

	wb_state_e state;
	logic      start;
	logic      finish;

	// the requester still holds valid while done is high, so skip that cycle
	assign start  = (state == wb_idle) && req.valid && !done;
	assign finish = (state == wb_active) && ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= wb_idle;
			cyc   <= 1'b0;
			stb   <= 1'b0;
			we    <= 1'b0;
			done  <= 1'b0;
		end else begin
			done <= finish;
			if (start) begin
				state <= wb_active;
				cyc   <= 1'b1;
				stb   <= 1'b1;
				we    <= req.write;
			end else if (finish) begin
				state <= wb_idle;
				cyc   <= 1'b0;
				stb   <= 1'b0;
				we    <= 1'b0;
			end
		end
	end

	// address and data held constant for the whole cycle
	always_ff @(posedge clk) begin
		if (start) begin
			adr   <= req.adr;
			dat_o <= req.wdata;
		end
		if (finish) begin
			rdata <= dat_i;
		end
	end

endmodule

// ==== hdl/insn_decode.sv ====
module insn_decode (
	input  logic                 clk,
	input  logic                 reset,
	output femto8_pkg::bus_req_t  req,
	input  logic                 done,
	input  logic [7:0]           rdata,
	output femto8_pkg::exec_cmd_t cmd,
	output logic [7:0]           operand,
	input  logic                 carry,
	input  logic                 zero,
	input  logic [7:0]           a_value,
	input  logic [7:0]           b_value,
	input  logic                 ip_load,
	input  logic [7:0]           ip_value
);
	import femto8_pkg::*;

	seq_state_e state;
	logic [7:0] ip;
	logic [7:0] opcode;
	logic [7:0] xfer_adr;
	logic [7:0] xfer_wdata;
	logic       xfer_we;
	logic       branch_taken;

	// tttt = zero value, zero test, carry value, carry test
	assign branch_taken = (opcode[0] && (opcode[1] == carry)) ||
		(opcode[2] && (opcode[3] == zero));

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= st_reset;
			xfer_we <= 1'b0;
		end else begin
			case (state)
				st_reset: begin
					ip    <= RESET_VECTOR;
					state <= st_select;
				end
				st_select: begin
					if (done) begin
						opcode <= rdata;
						ip     <= ip + 8'd1;
						state  <= st_decode;
					end
				end
				st_decode: begin
					xfer_we <= 1'b0;
					casez (opcode)
						8'b00??????: state <= st_compute;
						// immediate byte follows the opcode
						8'b01??????: begin
							xfer_adr <= ip;
							ip       <= ip + 8'd1;
							state    <= st_operand;
						end
						8'b11??????: begin
							xfer_adr <= b_value;
							state    <= st_operand;
						end
						8'b1001????: begin
							xfer_adr   <= {STORE_PAGE, opcode[3:0]};
							xfer_wdata <= a_value;
							xfer_we    <= 1'b1;
							state      <= st_operand;
						end
						8'b1010????: begin
							// target byte is skipped either way
							xfer_adr <= ip;
							ip       <= ip + 8'd1;
							state    <= branch_taken ? st_read_ip : st_select;
						end
						SWAP_OPCODE, CLC_OPCODE: state <= st_compute;
						default: state <= st_reset;
					endcase
				end
				st_operand: begin
					if (done) begin
						operand <= rdata;
						state   <= xfer_we ? st_select : st_compute;
					end
				end
				st_compute: begin
					if (ip_load) begin
						ip <= ip_value;
					end
					state <= st_select;
				end
				st_read_ip: begin
					if (done) begin
						ip    <= rdata;
						state <= st_select;
					end
				end
				default: state <= st_reset;
			endcase
		end
	end

	// request held for as long as the state waits on done
	always_comb begin
		req = '0;
		case (state)
			st_select: begin
				req.valid = 1'b1;
				req.adr   = ip;
			end
			st_operand, st_read_ip: begin
				req.valid = 1'b1;
				req.write = xfer_we;
				req.adr   = xfer_adr;
				req.wdata = xfer_wdata;
			end
			default: ;
		endcase
	end

	always_comb begin
		cmd = '0;
		if (state == st_compute) begin
			cmd.alu_op    = alu_op_e'(opcode[3:0]);
			cmd.dest      = dest_e'(opcode[5:4]);
			cmd.from_bus  = opcode[6];
			// ops 4-7 and 12-15 produce a carry
			cmd.flag_en   = opcode[2];
			cmd.swap      = (opcode == SWAP_OPCODE);
			cmd.clr_carry = (opcode == CLC_OPCODE);
			cmd.valid     = !opcode[7] || opcode[6];
		end
	end

endmodule

// ==== hdl/alu_execute.sv ====
module alu_execute (
	input  femto8_pkg::exec_cmd_t   cmd,
	input  logic [7:0]             a_value,
	input  logic [7:0]             b_value,
	input  logic [7:0]             operand,
	input  logic                   carry,
	output femto8_pkg::alu_result_t result
);
	import femto8_pkg::*;

	logic [7:0] a;
	logic [7:0] b;
	logic [8:0] y;

	assign a = a_value;
	// immediate and read-[B] forms take the byte from the bus
	assign b = cmd.from_bus ? operand : b_value;

	always_comb begin
		case (cmd.alu_op)
			op_zero:   y = 9'd0;
			op_load_a: y = {1'b0, a};
			op_inc:    y = {1'b0, a} + 9'd1;
			op_dec:    y = {1'b0, a} - 9'd1;
			// shifted-out bit lands in bit 8
			op_asl:    y = {a, 1'b0};
			op_lsr:    y = {a[0], 1'b0, a[7:1]};
			op_rol:    y = {a, carry};
			op_ror:    y = {a[0], carry, a[7:1]};
			op_or:     y = {1'b0, a | b};
			op_and:    y = {1'b0, a & b};
			op_xor:    y = {1'b0, a ^ b};
			op_load_b: y = {1'b0, b};
			op_add:    y = {1'b0, a} + {1'b0, b};
			// bit 8 is the borrow
			op_sub:    y = {1'b0, a} - {1'b0, b};
			op_adc:    y = {1'b0, a} + {1'b0, b} + {8'd0, carry};
			op_sbb:    y = {1'b0, a} - {1'b0, b} - {8'd0, carry};
			default:   y = 9'd0;
		endcase
	end

	assign result = alu_result_t'(y);

endmodule

// ==== hdl/result_writeback.sv ====
module result_writeback (
	input  logic                   clk,
	input  logic                   reset,
	input  femto8_pkg::exec_cmd_t   cmd,
	input  femto8_pkg::alu_result_t result,
	output logic [7:0]             a_value,
	output logic [7:0]             b_value,
	output logic                   carry,
	output logic                   zero,
	output logic                   ip_load,
	output logic [7:0]             ip_value
);
	import femto8_pkg::*;

	logic write_a;
	logic write_b;

	assign write_a = cmd.valid && (cmd.dest == dest_a);
	assign write_b = cmd.valid && (cmd.dest == dest_b);

	// jump target goes straight back to the sequencer in the compute cycle
	assign ip_load  = cmd.valid && (cmd.dest == dest_ip);
	assign ip_value = result.value;

	always_ff @(posedge clk) begin
		if (reset) begin
			a_value <= 8'd0;
			b_value <= 8'd0;
		end else if (cmd.swap) begin
			a_value <= b_value;
			b_value <= a_value;
		end else begin
			if (write_a) begin
				a_value <= result.value;
			end
			if (write_b) begin
				b_value <= result.value;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			carry <= 1'b0;
			zero  <= 1'b0;
		end else begin
			// zero follows every compute, even with no destination
			if (cmd.valid) begin
				zero <= ~|result.value;
				if (cmd.flag_en) begin
					carry <= result.carry;
				end
			end
			if (cmd.clr_carry) begin
				carry <= 1'b0;
			end
		end
	end

endmodule

// ==== hdl/femto8_core.sv ====
module femto8_core (
	input  logic       clk,
	input  logic       reset,
	output logic       cyc,
	output logic       stb,
	output logic       we,
	output logic [7:0] adr,
	output logic [7:0] dat_o,
	input  logic [7:0] dat_i,
	input  logic       ack
);
	import femto8_pkg::*;

	bus_req_t    req;
	logic        done;
	logic [7:0]  rdata;
	exec_cmd_t   cmd;
	logic [7:0]  operand;
	alu_result_t result;
	logic [7:0]  a_value;
	logic [7:0]  b_value;
	logic        carry;
	logic        zero;
	logic        ip_load;
	logic [7:0]  ip_value;

	insn_decode i_insn_decode (
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.done     (done),
		.rdata    (rdata),
		.cmd      (cmd),
		.operand  (operand),
		.carry    (carry),
		.zero     (zero),
		.a_value  (a_value),
		.b_value  (b_value),
		.ip_load  (ip_load),
		.ip_value (ip_value)
	);

	alu_execute i_alu_execute (
		.cmd     (cmd),
		.a_value (a_value),
		.b_value (b_value),
		.operand (operand),
		.carry   (carry),
		.result  (result)
	);

	result_writeback i_result_writeback (
		.clk      (clk),
		.reset    (reset),
		.cmd      (cmd),
		.result   (result),
		.a_value  (a_value),
		.b_value  (b_value),
		.carry    (carry),
		.zero     (zero),
		.ip_load  (ip_load),
		.ip_value (ip_value)
	);

	wb_master i_wb_master (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.done  (done),
		.rdata (rdata),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_o (dat_o),
		.dat_i (dat_i),
		.ack   (ack)
	);

endmodule

// ==== dv/femto8_chk.sv ====
module femto8_chk (
	input logic       clk,
	input logic       reset,
	input logic       cyc,
	input logic       stb,
	input logic       we,
	input logic       ack,
	input logic [7:0] adr,
	input logic [7:0] dat_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// number of assertion failures seen so far
	int failures = 0;

	stb_needs_cyc: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
		else begin
			$error("stb high while cyc is low");
			failures++;
		end

	// master holds the transfer until the slave acks
	hold_until_ack: assert property (@(posedge clk) disable iff (reset)
		(stb && !ack) |=> ($stable(adr) && $stable(we) && $stable(dat_o)))
		else begin
			$error("address, data or we changed during a wait state");
			failures++;
		end

	idle_after_reset: assert property (@(posedge clk) reset |=> !cyc)
		else begin
			$error("cyc high in the cycle after reset");
			failures++;
		end

endmodule

bind femto8_core femto8_chk i_femto8_chk (.*);

// ==== dv/tb_monitor.sv ====
module tb_monitor (
	input  logic       clk,
	input  logic       reset,
	input  logic       cyc,
	input  logic       stb,
	input  logic       we,
	input  logic       ack,
	input  logic [7:0] adr,
	input  logic [7:0] dat_o,
	output logic       test_done,
	output int         errors
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0] exp_adr [0:63];
	logic [7:0] exp_dat [0:63];
	int expected_n = 0;
	int seen_n = 0;
	int test_no = 0;
	int test_errors = 0;
	int passed = 0;
	int failed = 0;

	initial errors = 0;

	assign test_done = (expected_n != 0) && (seen_n == expected_n);

	task automatic begin_test(input int num);
		test_no = num;
		expected_n = 0;
		seen_n = 0;
		test_errors = 0;
	endtask

	task automatic add_expected(input logic [7:0] a, input logic [7:0] d);
		exp_adr[expected_n] = a;
		exp_dat[expected_n] = d;
		expected_n = expected_n + 1;
	endtask

	// a completed write is cyc, stb, we and ack in the same cycle
	always @(posedge clk) begin
		if (!reset && cyc && stb && we && ack) begin
			if (seen_n >= expected_n) begin
				$display("test %0d: store to %02h beyond the expected list", test_no, adr);
				errors = errors + 1;
				test_errors = test_errors + 1;
			end else begin
				if (adr !== exp_adr[seen_n]) begin
					$display("CHECK FAILED test %0d store %0d: adr got %02h expected %02h",
						test_no, seen_n, adr, exp_adr[seen_n]);
					errors = errors + 1;
					test_errors = test_errors + 1;
				end
				if (dat_o !== exp_dat[seen_n]) begin
					$display("CHECK FAILED test %0d store %0d: dat_o got %02h expected %02h",
						test_no, seen_n, dat_o, exp_dat[seen_n]);
					errors = errors + 1;
					test_errors = test_errors + 1;
				end
				seen_n = seen_n + 1;
			end
		end
	end

	task automatic end_test();
		if (test_errors == 0) begin
			passed = passed + 1;
			$display("test %0d: passed, %0d stores matched", test_no, seen_n);
		end else begin
			failed = failed + 1;
			$display("test %0d: failed with %0d errors", test_no, test_errors);
		end
	endtask

	task automatic print_counts();
		$display("tests run %0d, passed %0d, failed %0d, check errors %0d",
			passed + failed, passed, failed, errors);
	endtask

endmodule

// ==== dv/tb_femto8.sv ====
module tb_femto8;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RECORD_SIZE  = 128;
	localparam int MAX_TESTS    = 8;
	localparam int PROG_OFFSET  = 16;
	localparam int STORE_OFFSET = 64;

	logic       clk;
	logic       reset;
	logic       cyc;
	logic       stb;
	logic       we;
	logic       ack;
	logic [7:0] adr;
	logic [7:0] dat_o;
	logic [7:0] dat_i;
	logic       test_done;
	int         errors;

	logic [7:0] mem [0:255];
	logic [7:0] testdata [0:RECORD_SIZE * MAX_TESTS - 1];
	logic        wait_mode;
	logic        busy;
	int unsigned wait_left;
	int unsigned wait_now;
	int unsigned cycle_count = 0;
	int unsigned cycle_limit = 0;
	int          test_count;

	femto8_core i_femto8_core (
		.clk   (clk),
		.reset (reset),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_o (dat_o),
		.dat_i (dat_i),
		.ack   (ack)
	);

	tb_monitor i_tb_monitor (
		.clk       (clk),
		.reset     (reset),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.ack       (ack),
		.adr       (adr),
		.dat_o     (dat_o),
		.test_done (test_done),
		.errors    (errors)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic int unsigned pick_waits();
		if (wait_mode) begin
			return $urandom % 4;
		end
		return 0;
	endfunction

	// wait count drawn when a transfer first shows up
	always @(posedge clk) begin
		if (reset) begin
			ack       <= 1'b0;
			busy      <= 1'b0;
			wait_left <= 0;
		end else if (ack) begin
			ack  <= 1'b0;
			busy <= 1'b0;
		end else if (cyc && stb) begin
			wait_now = busy ? wait_left : pick_waits();
			busy <= 1'b1;
			if (wait_now == 0) begin
				ack   <= 1'b1;
				dat_i <= mem[adr];
				if (we) begin
					mem[adr] <= dat_o;
				end
			end else begin
				wait_left <= wait_now - 1;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, expected stores never arrived", cycle_count);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic load_test(input int num);
		int base;
		int i;
		base = num * RECORD_SIZE;
		for (i = 0; i < 256; i++) begin
			mem[i] = i[7:0] ^ 8'ha5;
		end
		for (i = 0; i < testdata[base + 2]; i++) begin
			mem[8'h80 + i] = testdata[base + PROG_OFFSET + i];
		end
		wait_mode <= testdata[base][0];
		i_tb_monitor.begin_test(num + 1);
		for (i = 0; i < testdata[base + 1]; i++) begin
			i_tb_monitor.add_expected(testdata[base + STORE_OFFSET + 2 * i],
				testdata[base + STORE_OFFSET + 2 * i + 1]);
		end
	endtask

	initial begin
		int i;
		int t;
		int unsigned budget;
		int asserts_failed;
		reset     = 1'b1;
		ack       = 1'b0;
		dat_i     = 8'h00;
		wait_mode = 1'b0;
		busy      = 1'b0;
		wait_left = 0;
		void'($urandom(54403));
		for (i = 0; i < RECORD_SIZE * MAX_TESTS; i++) begin
			testdata[i] = 8'h00;
		end
		$readmemh("dv/femto8_testdata.txt", testdata);

		// each instruction gets 4 transfers of 5 cycles
		test_count = 0;
		budget = 1000;
		while (test_count < MAX_TESTS && testdata[test_count * RECORD_SIZE + 1] != 0) begin
			budget = budget + testdata[test_count * RECORD_SIZE + 3] * 20 + 8;
			test_count = test_count + 1;
		end
		cycle_limit = budget;

		for (t = 0; t < test_count; t++) begin
			@(posedge clk);
			reset <= 1'b1;
			@(posedge clk);
			load_test(t);
			repeat (7) @(posedge clk);
			reset <= 1'b0;
			@(negedge clk);
			while (!test_done) begin
				@(negedge clk);
			end
			i_tb_monitor.end_test();
		end

		i_tb_monitor.print_counts();
		asserts_failed = i_femto8_core.i_femto8_chk.failures;
		if (test_count == 0) begin
			$display("no tests found in the data file");
		end
		if (asserts_failed != 0) begin
			$display("bus protocol assertions failed %0d times", asserts_failed);
		end
		if (test_count != 0 && errors == 0 && asserts_failed == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== dv/femto8_testdata.txt ====
// record per test every 0x80 words: mode (1 = random waits), store count, program bytes, insns
// then the program image from +0x10 (loaded at 0x80) and store address/data pairs from +0x40
// alu operations with destinations a and b
@000
00 12 2e 30
@010
4b 3a 5b 5c 0c 90 0d 91 08 92 09 93 0a 94 03 95
02 96 0b 97 04 98 04 99 06 9a 07 9b 05 9c 0e 9d
0f 9e 00 9f 4b 21 1c 81 90 12 81 91 6b ac
@040
00 96 01 3a 02 7e 03 5c 04 00 05 ff 06 00 07 5c
08 b8 09 70 0a e1 0b 70 0c 38 0d 94 0e 38 0f 00
00 7d 01 7e
// carry and zero flags, clear carry, destination none
@080
00 08 28 28
@090
4b ff 5b 01 0e 90 0e 91 4b ff 0c 02 0e 92 4b 80
04 88 0e 93 3d ac 99 94 80 95 4b 00 0f 96 0f 97
88 4b 03 07 07 98 6b a6
@0c0
00 00 01 02 02 03 03 01 05 01 06 ff 07 fd 08 80
// read-[b] operands from earlier stores
@100
00 05 15 18
@110
4b 11 95 4b 22 96 5b 05 cc 97 5b 07 db 0c 98 5b
06 cd 99 6b 93
@140
05 11 06 22 07 33 08 66 09 44
// branches, jumps and a fibonacci loop
@180
00 0e 18 50
@190
4b 01 5b 01 90 0c a3 8c 81 6b 84 80 91 a1 8b 4b
5a 6b 95 92 80 93 6b 96
@1c0
00 01 00 01 00 02 00 03 00 05 00 08 00 0d 00 15
00 22 00 37 00 59 00 90 01 79 03 5a
// swap, then an undefined opcode restarts at 0x80
@200
00 06 09 20
@210
4b 12 5b 34 81 90 81 91 82
@240
00 34 01 12 00 34 01 12 00 34 01 12
// fibonacci program again with random wait states
@280
01 0e 18 50
@290
4b 01 5b 01 90 0c a3 8c 81 6b 84 80 91 a1 8b 4b
5a 6b 95 92 80 93 6b 96
@2c0
00 01 00 01 00 02 00 03 00 05 00 08 00 0d 00 15
00 22 00 37 00 59 00 90 01 79 03 5a

// ==== vlog.f ====
hdl/femto8_pkg.sv
hdl/wb_master.sv
hdl/insn_decode.sv
hdl/alu_execute.sv
hdl/result_writeback.sv
hdl/femto8_core.sv
dv/femto8_chk.sv
dv/tb_monitor.sv
dv/tb_femto8.sv
